/* app_core.sv */
`timescale 1ns/1ps
`include "app_defines.svh"

module app_core (
   input  logic                       core_clk,
   input  logic                       arst_n,
   input  logic [`APP_TS_W-1:0]       timestamp,
   // Ingress stream
   input  logic                       s_tvalid,
   output logic                       s_tready,
   input  logic [`APP_DATA_W-1:0]     s_tdata,
   input  logic [7:0]                 s_tkeep,
   input  logic                       s_tlast,
   input  logic [`APP_PORT_W-1:0]     s_tid,
   input  logic [15:0]                s_tuser_pid,
   // Egress stream
   output logic                       m_tvalid,
   input  logic                       m_tready,
   output logic [`APP_DATA_W-1:0]     m_tdata,
   output logic [7:0]                 m_tkeep,
   output logic                       m_tlast,
   output logic [`APP_PORT_W-1:0]     m_tdest,
   output logic [15:0]                m_tuser_pid,
   output logic                       m_tuser_rss_enable,
   output logic [11:0]                m_tuser_rss_entropy,
   // Register port
   input  logic                       reg_wr_en,
   input  logic                       reg_rd_en,
   input  logic [`APP_REG_ADDR_W-1:0] reg_addr,
   input  logic [31:0]                reg_wdata,
   output logic [31:0]                reg_rdata
);

   import app_pkg::*;

   table_array_t table_entries;
   logic         pkt_done;
   logic         pkt_dropped;

   app_stream_if dec_to_exe ();
   app_stream_if exe_to_res ();

   // ----------------------------------------
   // Decode, execute, result
   // ----------------------------------------
   meta_decoder u_decode (
      .core_clk, .arst_n, .s_tvalid, .s_tdata, .s_tkeep, .s_tlast, .s_tid, .s_tuser_pid,
      .timestamp, .s_tready,
      .out (dec_to_exe.src)
   );

   match_action u_execute (
      .core_clk, .arst_n, .table_entries,
      .in  (dec_to_exe.dst),
      .out (exe_to_res.src)
   );

   result_stage u_result (
      .core_clk, .arst_n,
      .in (exe_to_res.dst),
      .m_tvalid, .m_tready, .m_tdata, .m_tkeep, .m_tlast, .m_tdest,
      .m_tuser_pid, .m_tuser_rss_enable, .m_tuser_rss_entropy,
      .pkt_done, .pkt_dropped
   );

   // Register block
   app_regs u_regs (
      .core_clk, .arst_n, .reg_wr_en, .reg_rd_en, .reg_addr, .reg_wdata, .reg_rdata,
      .pkt_done, .pkt_dropped, .table_entries
   );

endmodule

/* app_core_checker.sv */
`timescale 1ns/1ps
`include "app_defines.svh"

module app_core_checker (
   input logic                   core_clk,
   input logic                   arst_n,
   input logic                   m_tvalid,
   input logic                   m_tready,
   input logic [`APP_DATA_W-1:0] m_tdata,
   input logic [31:0]            reg_rdata
);

   // ----------------------------------------
   // Egress stream
   // ----------------------------------------
   property egress_hold;
      @(posedge core_clk) disable iff (!arst_n)
         m_tvalid && !m_tready |=> $stable(m_tdata);
   endproperty

   assert property (egress_hold) else $error("m_tdata changed while stalled");

   assert property (@(posedge core_clk) !arst_n |-> !m_tvalid)
      else $error("m_tvalid high during reset");

   // Register read data
   assert property (@(posedge core_clk) !arst_n |-> reg_rdata == 32'd0)
      else $error("reg_rdata not zero during reset");

endmodule

bind app_core app_core_checker u_checker (
   .core_clk  (core_clk),
   .arst_n    (arst_n),
   .m_tvalid  (m_tvalid),
   .m_tready  (m_tready),
   .m_tdata   (m_tdata),
   .reg_rdata (reg_rdata)
);

/* app_defines.svh */
`ifndef APP_DEFINES_SVH
`define APP_DEFINES_SVH

// Stream data path
`define APP_DATA_W 64

// Port id width and match table depth
`define APP_PORT_W    2
`define APP_NUM_PORTS 4

// Register port address
`define APP_REG_ADDR_W 4

// Free-running timestamp from the shell
`define APP_TS_W 64

`endif

/* app_pkg.sv */
`include "app_defines.svh"

package app_pkg;

   // ----------------------------------------
   // Stream and metadata types
   // ----------------------------------------
   typedef struct packed {
      logic [`APP_TS_W-1:0]   timestamp;
      logic [15:0]            pid;
      logic [`APP_PORT_W-1:0] ingress_port;
      logic [`APP_PORT_W-1:0] egress_port;
      logic                   rss_enable;
      logic [11:0]            rss_entropy;
      logic                   drop;
   } app_meta_t;

   typedef struct packed {
      logic [`APP_DATA_W-1:0] tdata;
      logic [7:0]             tkeep;
      logic                   tlast;
      logic                   sop;
   } app_beat_t;

   // Beat plus metadata, moved between the internal stages
   typedef struct packed {
      app_beat_t beat;
      app_meta_t meta;
   } app_word_t;

   typedef struct packed {
      logic [`APP_DATA_W-1:0] tdata;
      logic [7:0]             tkeep;
      logic                   tlast;
      logic [`APP_PORT_W-1:0] tdest;
      logic [15:0]            pid;
      logic                   rss_enable;
      logic [11:0]            rss_entropy;
   } app_egress_t;

   // ----------------------------------------
   // Match table
   // ----------------------------------------
   typedef struct packed {
      logic [`APP_PORT_W-1:0] egress_port;
      logic                   rss_enable;
      logic                   drop;
   } table_entry_t;

   typedef table_entry_t [`APP_NUM_PORTS-1:0] table_array_t;

   // Register map
   localparam logic [`APP_REG_ADDR_W-1:0] REG_TABLE_BASE = `APP_REG_ADDR_W'(0);
   localparam logic [`APP_REG_ADDR_W-1:0] REG_PKT_COUNT  = `APP_REG_ADDR_W'(4);
   localparam logic [`APP_REG_ADDR_W-1:0] REG_DROP_COUNT = `APP_REG_ADDR_W'(5);

   // XOR of the five 12-bit slices in bits 59:0
   function automatic logic [11:0] rss_fold(input logic [`APP_DATA_W-1:0] data);
      logic [11:0] acc;
      acc = '0;
      for (int i = 0; i < 5; i++) begin
         acc = acc ^ data[i*12 +: 12];
      end
      return acc;
   endfunction

endpackage

/* app_regs.sv */
`timescale 1ns/1ps
`include "app_defines.svh"

module app_regs (
   input  logic                       core_clk,
   input  logic                       arst_n,
   input  logic                       reg_wr_en,
   input  logic                       reg_rd_en,
   input  logic [`APP_REG_ADDR_W-1:0] reg_addr,
   input  logic [31:0]                reg_wdata,
   output logic [31:0]                reg_rdata,
   input  logic                       pkt_done,
   input  logic                       pkt_dropped,
   output app_pkg::table_array_t      table_entries
);

   import app_pkg::*;

   logic [31:0]                pkt_count;
   logic [31:0]                drop_count;
   logic [`APP_REG_ADDR_W-1:0] tbl_off;
   logic                       tbl_hit;
   table_entry_t               rd_entry;

   assign tbl_off  = reg_addr - REG_TABLE_BASE;
   assign tbl_hit  = tbl_off < `APP_REG_ADDR_W'(`APP_NUM_PORTS);
   assign rd_entry = table_entries[tbl_off[`APP_PORT_W-1:0]];

   // ----------------------------------------
   // Table and counters
   // ----------------------------------------
   always_ff @(posedge core_clk or negedge arst_n) begin
      if (!arst_n) begin
         // Identity mapping, RSS and drop off
         for (int i = 0; i < `APP_NUM_PORTS; i++) begin
            table_entries[i] <= '{egress_port: `APP_PORT_W'(i), rss_enable: 1'b0, drop: 1'b0};
         end
         pkt_count  <= '0;
         drop_count <= '0;
      end else begin
         if (reg_wr_en && tbl_hit) begin
            table_entries[tbl_off[`APP_PORT_W-1:0]] <= '{egress_port: reg_wdata[`APP_PORT_W-1:0],
                                                        rss_enable: reg_wdata[4],
                                                        drop: reg_wdata[8]};
         end
         if (pkt_done) pkt_count <= pkt_count + 32'd1;
         if (pkt_dropped) drop_count <= drop_count + 32'd1;
      end
   end

   // Registered read mux
   always_ff @(posedge core_clk or negedge arst_n) begin
      if (!arst_n) begin
         reg_rdata <= '0;
      end else if (reg_rd_en) begin
         reg_rdata <= '0;
         if (tbl_hit) begin
            reg_rdata[`APP_PORT_W-1:0] <= rd_entry.egress_port;
            reg_rdata[4]               <= rd_entry.rss_enable;
            reg_rdata[8]               <= rd_entry.drop;
         end else if (reg_addr == REG_PKT_COUNT) begin
            reg_rdata <= pkt_count;
         end else if (reg_addr == REG_DROP_COUNT) begin
            reg_rdata <= drop_count;
         end
      end
   end

endmodule

/* app_stream_if.sv */
`timescale 1ns/1ps

interface app_stream_if;

   import app_pkg::*;

   // Handshake
   logic valid;
   logic ready;

   // Beat and its metadata, held while valid and not ready
   app_word_t word;

   // ----------------------------------------
   // Producer side
   // ----------------------------------------
   modport src (
      output valid,
      output word,
      input  ready
   );

   // Consumer side
   modport dst (
      input  valid,
      input  word,
      output ready
   );

endinterface

/* filelist.f */
+incdir+.
app_pkg.sv
app_stream_if.sv
pipe_stage.sv
meta_decoder.sv
match_action.sv
result_stage.sv
app_regs.sv
app_core.sv
app_core_checker.sv
tb_app_core.sv

/* match_action.sv */
`timescale 1ns/1ps
`include "app_defines.svh"

module match_action (
   input  logic                  core_clk,
   input  logic                  arst_n,
   input  app_pkg::table_array_t table_entries,
   app_stream_if.dst             in,
   app_stream_if.src             out
);

   import app_pkg::*;

   table_entry_t hit;
   app_word_t    word_in;

   // ----------------------------------------
   // Lookup by ingress port
   // ----------------------------------------
   assign hit = table_entries[in.word.meta.ingress_port];

   always_comb begin
      word_in = in.word;
      // Only the sop beat is rewritten
      if (in.word.beat.sop) begin
         word_in.meta.egress_port = hit.egress_port;
         word_in.meta.rss_enable  = hit.rss_enable;
         word_in.meta.drop        = hit.drop;
         if (hit.rss_enable) begin
            word_in.meta.rss_entropy = rss_fold(in.word.beat.tdata);
         end else begin
            word_in.meta.rss_entropy = '0;
         end
      end
   end

   pipe_stage #(.payload_t(app_word_t)) u_stage (
      .core_clk  (core_clk),
      .arst_n    (arst_n),
      .in_valid  (in.valid),
      .in_ready  (in.ready),
      .in_data   (word_in),
      .out_valid (out.valid),
      .out_ready (out.ready),
      .out_data  (out.word)
   );

endmodule

/* meta_decoder.sv */
`timescale 1ns/1ps
`include "app_defines.svh"

module meta_decoder (
   input  logic                   core_clk,
   input  logic                   arst_n,
   input  logic                   s_tvalid,
   input  logic [`APP_DATA_W-1:0] s_tdata,
   input  logic [7:0]             s_tkeep,
   input  logic                   s_tlast,
   input  logic [`APP_PORT_W-1:0] s_tid,
   input  logic [15:0]            s_tuser_pid,
   input  logic [`APP_TS_W-1:0]   timestamp,
   output logic                   s_tready,
   app_stream_if.src              out
);

   import app_pkg::*;

   logic      in_pkt;
   app_word_t word_in;

   // ----------------------------------------
   // Start-of-packet tracking
   // ----------------------------------------
   always_ff @(posedge core_clk or negedge arst_n) begin
      if (!arst_n) begin
         in_pkt <= 1'b0;
      end else if (s_tvalid && s_tready) begin
         in_pkt <= !s_tlast;
      end
   end

   // Ingress metadata, egress defaults to the ingress port
   always_comb begin
      word_in.beat.tdata        = s_tdata;
      word_in.beat.tkeep        = s_tkeep;
      word_in.beat.tlast        = s_tlast;
      word_in.beat.sop          = !in_pkt;
      word_in.meta.timestamp    = timestamp;
      word_in.meta.pid          = s_tuser_pid;
      word_in.meta.ingress_port = s_tid;
      word_in.meta.egress_port  = s_tid;
      word_in.meta.rss_enable   = 1'b0;
      word_in.meta.rss_entropy  = '0;
      word_in.meta.drop         = 1'b0;
   end

   pipe_stage #(.payload_t(app_word_t)) u_stage (
      .core_clk  (core_clk),
      .arst_n    (arst_n),
      .in_valid  (s_tvalid),
      .in_ready  (s_tready),
      .in_data   (word_in),
      .out_valid (out.valid),
      .out_ready (out.ready),
      .out_data  (out.word)
   );

endmodule

/* pipe_stage.sv */
`timescale 1ns/1ps

module pipe_stage #(
   parameter type payload_t = logic
) (
   input  logic     core_clk,
   input  logic     arst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   // Take a new item when empty or when the current one leaves
   assign in_ready = !out_valid || out_ready;

   always_ff @(posedge core_clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;
      end
   end

   // Payload register
   always_ff @(posedge core_clk) begin
      if (in_valid && in_ready) begin
         out_data <= in_data;
      end
   end

endmodule

/* result_stage.sv */
`timescale 1ns/1ps
`include "app_defines.svh"

module result_stage (
   input  logic                   core_clk,
   input  logic                   arst_n,
   app_stream_if.dst              in,
   output logic                   m_tvalid,
   input  logic                   m_tready,
   output logic [`APP_DATA_W-1:0] m_tdata,
   output logic [7:0]             m_tkeep,
   output logic                   m_tlast,
   output logic [`APP_PORT_W-1:0] m_tdest,
   output logic [15:0]            m_tuser_pid,
   output logic                   m_tuser_rss_enable,
   output logic [11:0]            m_tuser_rss_entropy,
   output logic                   pkt_done,
   output logic                   pkt_dropped
);

   import app_pkg::*;

   app_meta_t   meta_hold;
   app_meta_t   meta_live;
   app_egress_t egr_in;
   app_egress_t egr_out;
   logic        stage_valid;
   logic        stage_ready;
   logic        accept;

   // ----------------------------------------
   // Per-packet metadata hold
   // ----------------------------------------
   assign meta_live = in.word.beat.sop ? in.word.meta : meta_hold;
   assign accept    = in.valid && in.ready;

   always_ff @(posedge core_clk) begin
      if (accept && in.word.beat.sop) begin
         meta_hold <= in.word.meta;
      end
   end

   // Dropped beats are swallowed here
   assign stage_valid = in.valid && !meta_live.drop;
   assign in.ready    = meta_live.drop || stage_ready;

   always_comb begin
      egr_in.tdata       = in.word.beat.tdata;
      egr_in.tkeep       = in.word.beat.tkeep;
      egr_in.tlast       = in.word.beat.tlast;
      egr_in.tdest       = meta_live.egress_port;
      egr_in.pid         = meta_live.pid;
      egr_in.rss_enable  = meta_live.rss_enable;
      egr_in.rss_entropy = meta_live.rss_entropy;
   end

   pipe_stage #(.payload_t(app_egress_t)) u_stage (
      .core_clk  (core_clk),
      .arst_n    (arst_n),
      .in_valid  (stage_valid),
      .in_ready  (stage_ready),
      .in_data   (egr_in),
      .out_valid (m_tvalid),
      .out_ready (m_tready),
      .out_data  (egr_out)
   );

   assign m_tdata             = egr_out.tdata;
   assign m_tkeep             = egr_out.tkeep;
   assign m_tlast             = egr_out.tlast;
   assign m_tdest             = egr_out.tdest;
   assign m_tuser_pid         = egr_out.pid;
   assign m_tuser_rss_enable  = egr_out.rss_enable;
   assign m_tuser_rss_entropy = egr_out.rss_entropy;

   // Packet events on the accepted tlast beat
   always_ff @(posedge core_clk or negedge arst_n) begin
      if (!arst_n) begin
         pkt_done    <= 1'b0;
         pkt_dropped <= 1'b0;
      end else begin
         pkt_done    <= accept && in.word.beat.tlast && !meta_live.drop;
         pkt_dropped <= accept && in.word.beat.tlast && meta_live.drop;
      end
   end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the app_core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f filelist.f --top-module tb_app_core -Mdir obj_dir

# A failing assertion can stop the run early, the log decides the result
./obj_dir/Vtb_app_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
   exit 1
fi
if ! grep -q "Verification passed" sim.log; then
   echo "Simulation ended without a result line"
   exit 1
fi

/* tb_app_core.sv */
`timescale 1ns/1ps
`include "app_defines.svh"

module tb_app_core;

   import app_pkg::*;

   localparam int NUM_ROWS = 10;

   // One packet per row, with an optional table write ahead of it
   typedef struct packed {
      logic [`APP_PORT_W-1:0] port;
      logic [15:0]            pid;
      logic [3:0]             len;
      logic [`APP_DATA_W-1:0] data;
      logic                   cfg_en;
      logic [`APP_PORT_W-1:0] cfg_idx;
      logic [8:0]             cfg_val;
   } row_t;

   logic                       core_clk;
   logic                       arst_n;
   logic [`APP_TS_W-1:0]       timestamp;
   logic                       s_tvalid;
   logic                       s_tready;
   logic [`APP_DATA_W-1:0]     s_tdata;
   logic [7:0]                 s_tkeep;
   logic                       s_tlast;
   logic [`APP_PORT_W-1:0]     s_tid;
   logic [15:0]                s_tuser_pid;
   logic                       m_tvalid;
   logic                       m_tready;
   logic [`APP_DATA_W-1:0]     m_tdata;
   logic [7:0]                 m_tkeep;
   logic                       m_tlast;
   logic [`APP_PORT_W-1:0]     m_tdest;
   logic [15:0]                m_tuser_pid;
   logic                       m_tuser_rss_enable;
   logic [11:0]                m_tuser_rss_entropy;
   logic                       reg_wr_en;
   logic                       reg_rd_en;
   logic [`APP_REG_ADDR_W-1:0] reg_addr;
   logic [31:0]                reg_wdata;
   logic [31:0]                reg_rdata;

   app_egress_t  exp_q [$];
   table_entry_t model_tbl [`APP_NUM_PORTS];
   int           errors;
   int           beats_seen;
   int           delivered;
   int           dropped;

   row_t rows [NUM_ROWS] = '{
      '{2'd0, 16'h1a00, 4'd3, 64'h0123_4567_89ab_cdef, 1'b0, 2'd0, 9'h000},
      '{2'd1, 16'h1a01, 4'd1, 64'hfedc_ba98_7654_3210, 1'b0, 2'd0, 9'h000},
      '{2'd2, 16'h1a02, 4'd2, 64'h0f0f_1234_5678_a5a5, 1'b0, 2'd0, 9'h000},
      // Port 3 moved to egress 1 with RSS on
      '{2'd3, 16'h1a03, 4'd4, 64'hdead_beef_cafe_f00d, 1'b1, 2'd3, 9'h011},
      // Port 2 dropped from here on
      '{2'd2, 16'h1a04, 4'd3, 64'h1111_2222_3333_4444, 1'b1, 2'd2, 9'h102},
      '{2'd1, 16'h1a05, 4'd2, 64'h5555_6666_7777_8888, 1'b0, 2'd0, 9'h000},
      '{2'd2, 16'h1a06, 4'd1, 64'h9999_aaaa_bbbb_cccc, 1'b0, 2'd0, 9'h000},
      '{2'd3, 16'h1a07, 4'd3, 64'h0a0b_0c0d_0e0f_1011, 1'b0, 2'd0, 9'h000},
      '{2'd0, 16'h1a08, 4'd5, 64'h7e57_da7a_0000_ffff, 1'b1, 2'd0, 9'h012},
      '{2'd1, 16'h1a09, 4'd2, 64'h3c3c_4b4b_5a5a_6969, 1'b0, 2'd0, 9'h000}
   };

   app_core uut (.*);

   always #5 core_clk = ~core_clk;

   always @(negedge core_clk) begin
      timestamp <= timestamp + 64'd1;
   end

   // Five 12-bit slices of bits 59:0 folded by XOR
   function automatic logic [11:0] entropy_of(input logic [`APP_DATA_W-1:0] d);
      return d[11:0] ^ d[23:12] ^ d[35:24] ^ d[47:36] ^ d[59:48];
   endfunction

   task automatic compare_field(input string name, input logic [63:0] got,
                                input logic [63:0] want);
      assert (got == want) else begin
         $display("** Error at %0t: %s is %h, expected %h", $time, name, got, want);
         errors++;
      end
   endtask

   task automatic idle(input int unsigned n);
      repeat (n) begin
         @(negedge core_clk);
         s_tvalid = 1'b0;
      end
   endtask

   // Wait until every expected beat has left and dropped beats are flushed
   task automatic drain();
      idle(1);
      while (exp_q.size() != 0) @(negedge core_clk);
      idle(6);
   endtask

   task automatic write_reg(input logic [`APP_REG_ADDR_W-1:0] addr, input logic [31:0] data);
      @(negedge core_clk);
      reg_wr_en = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(negedge core_clk);
      reg_wr_en = 1'b0;
   endtask

   task automatic read_reg(input logic [`APP_REG_ADDR_W-1:0] addr, output logic [31:0] data);
      @(negedge core_clk);
      reg_rd_en = 1'b1;
      reg_addr  = addr;
      @(negedge core_clk);
      reg_rd_en = 1'b0;
      data      = reg_rdata;
   endtask

   // ----------------------------------------
   // Packet driver and expected beats
   // ----------------------------------------
   task automatic send_packet(input row_t r);
      table_entry_t        ent;
      app_egress_t         e;
      logic [`APP_DATA_W-1:0] d;
      logic                ready_seen;
      ent = model_tbl[r.port];
      for (int k = 0; k < int'(r.len); k++) begin
         d             = r.data ^ {8{8'(k)}};
         e.tdata       = d;
         e.tkeep       = (k == int'(r.len) - 1) ? 8'h0F : 8'hFF;
         e.tlast       = (k == int'(r.len) - 1);
         e.tdest       = ent.egress_port;
         e.pid         = r.pid;
         e.rss_enable  = ent.rss_enable;
         e.rss_entropy = ent.rss_enable ? entropy_of(r.data) : 12'h000;
         if (!ent.drop) exp_q.push_back(e);
         @(negedge core_clk);
         s_tvalid    = 1'b1;
         s_tdata     = d;
         s_tkeep     = e.tkeep;
         s_tlast     = e.tlast;
         s_tid       = r.port;
         s_tuser_pid = r.pid;
         ready_seen  = 1'b0;
         while (!ready_seen) begin
            #2 ready_seen = s_tready;
            if (ready_seen) @(posedge core_clk);
            else @(negedge core_clk);
         end
      end
      if (ent.drop) dropped++;
      else delivered++;
   endtask

   // Random sink stalls, beats scored just before the edge that moves them
   initial begin : egress_monitor
      app_egress_t want;
      forever begin
         @(negedge core_clk);
         m_tready = ($urandom % 4) != 0;
         #3;
         if (arst_n && m_tvalid && m_tready) begin
            assert (exp_q.size() != 0) else begin
               $display("Egress beat at %0t with no beat expected", $time);
               errors++;
            end
            if (exp_q.size() != 0) begin
               want = exp_q.pop_front();
               compare_field("m_tdata", m_tdata, want.tdata);
               compare_field("m_tkeep", 64'(m_tkeep), 64'(want.tkeep));
               compare_field("m_tlast", 64'(m_tlast), 64'(want.tlast));
               compare_field("m_tdest", 64'(m_tdest), 64'(want.tdest));
               compare_field("m_tuser_pid", 64'(m_tuser_pid), 64'(want.pid));
               compare_field("m_tuser_rss_enable", 64'(m_tuser_rss_enable),
                             64'(want.rss_enable));
               compare_field("m_tuser_rss_entropy", 64'(m_tuser_rss_entropy),
                             64'(want.rss_entropy));
               beats_seen++;
            end
         end
      end
   end

   initial begin : watchdog
      int beats;
      beats = 0;
      for (int i = 0; i < NUM_ROWS; i++) beats += int'(rows[i].len);
      #((beats * 16 + NUM_ROWS * 40 + 300) * 10);
      $display("Timeout after %0t with %0d expected beats still pending", $time, exp_q.size());
      $display("Verification failed");
      $finish;
   end

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial begin : stimulus
      logic [31:0]            rdata;
      int unsigned            gap;
      logic [`APP_PORT_W-1:0] last_idx;
      logic [8:0]             last_val;
      void'($urandom(77));
      core_clk    = 1'b0;
      arst_n      = 1'b1;
      timestamp   = '0;
      s_tvalid    = 1'b0;
      s_tdata     = '0;
      s_tkeep     = '0;
      s_tlast     = 1'b0;
      s_tid       = '0;
      s_tuser_pid = '0;
      m_tready    = 1'b0;
      reg_wr_en   = 1'b0;
      reg_rd_en   = 1'b0;
      reg_addr    = '0;
      reg_wdata   = '0;
      errors      = 0;
      beats_seen  = 0;
      delivered   = 0;
      dropped     = 0;
      last_idx    = '0;
      last_val    = 9'h000;
      for (int i = 0; i < `APP_NUM_PORTS; i++) begin
         model_tbl[i] = '{`APP_PORT_W'(i), 1'b0, 1'b0};
      end
      // Async reset edge right after time zero
      #1 arst_n = 1'b0;
      repeat (2) @(posedge core_clk);
      @(negedge core_clk);
      arst_n = 1'b1;

      for (int i = 0; i < NUM_ROWS; i++) begin
         if (rows[i].cfg_en) begin
            drain();
            write_reg(REG_TABLE_BASE + `APP_REG_ADDR_W'(rows[i].cfg_idx),
                      {23'd0, rows[i].cfg_val});
            model_tbl[rows[i].cfg_idx] = '{rows[i].cfg_val[1:0], rows[i].cfg_val[4],
                                           rows[i].cfg_val[8]};
            last_idx = rows[i].cfg_idx;
            last_val = rows[i].cfg_val;
         end
         send_packet(rows[i]);
         // Even rows run straight into the next packet
         gap = (i % 2 == 0) ? 0 : $urandom % 3;
         if (gap != 0) idle(gap);
      end
      drain();

      // Counters and table readback
      read_reg(REG_PKT_COUNT, rdata);
      compare_field("reg_rdata pkt_count", 64'(rdata), 64'(delivered));
      read_reg(REG_DROP_COUNT, rdata);
      compare_field("reg_rdata drop_count", 64'(rdata), 64'(dropped));
      read_reg(REG_TABLE_BASE + `APP_REG_ADDR_W'(last_idx), rdata);
      compare_field("reg_rdata table", 64'(rdata), 64'(last_val));

      $display("Errors: %0d, beats checked: %0d, packets delivered: %0d, dropped: %0d",
               errors, beats_seen, delivered, dropped);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
